// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31; // jal return address
    localparam logic [word_w-1:0]     pc_step  = 32'd4;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special instructions, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_jr   = 6'h08,
        fn_jalr = 6'h09,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {src1_rs, src1_pc, src1_sa, src1_none} src1_sel_e;

    typedef enum logic [2:0] {
        src2_rt, src2_simm, src2_eight, src2_zimm, src2_none
    } src2_sel_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_j, br_jal, br_jr, br_jalr
    } branch_kind_e;

    typedef struct packed {
        logic id_stop;
        logic ex_stop;
    } stall_t;

    typedef struct packed {
        logic              valid;
        logic [word_w-1:0] pc;
        logic [word_w-1:0] inst;
    } fetch_t;

    // write-back port and forward buses share this layout
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [word_w-1:0]     data;
    } rf_write_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs_addr;
        logic [reg_addr_w-1:0] rt_addr;
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  mem_en;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        branch_kind_e          br_kind;
    } ctrl_t;

    typedef struct packed {
        logic [word_w-1:0]     pc;
        logic [word_w-1:0]     inst;
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  mem_en;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [word_w-1:0]     rs_value;
        logic [word_w-1:0]     rt_value;
    } id_to_ex_t;

    typedef struct packed {
        logic              taken;
        logic [word_w-1:0] target;
    } branch_t;

endpackage

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire decode_pkg::fetch_t fetched,
    output decode_pkg::ctrl_t       ctrl
);

    decode_pkg::opcode_e opcode;
    decode_pkg::funct_e  funct;
    logic [decode_pkg::reg_addr_w-1:0] rd;
    logic known;

    assign opcode = decode_pkg::opcode_e'(fetched.inst[31:26]);
    assign funct  = decode_pkg::funct_e'(fetched.inst[5:0]);
    assign rd     = fetched.inst[15:11];

    always_comb begin
        ctrl.rs_addr  = fetched.inst[25:21];
        ctrl.rt_addr  = fetched.inst[20:16];
        ctrl.alu_op   = decode_pkg::alu_none;
        ctrl.src1_sel = decode_pkg::src1_none;
        ctrl.src2_sel = decode_pkg::src2_none;
        ctrl.mem_en   = 1'b0;
        ctrl.mem_we   = 1'b0;
        ctrl.rf_we    = 1'b0;
        ctrl.rf_waddr = '0;
        ctrl.br_kind  = decode_pkg::br_none;
        known         = 1'b1;

        case (opcode)
            decode_pkg::op_special: begin
                // R-type default: rs op rt -> rd
                ctrl.src1_sel = decode_pkg::src1_rs;
                ctrl.src2_sel = decode_pkg::src2_rt;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = rd;
                case (funct)
                    decode_pkg::fn_add, decode_pkg::fn_addu: ctrl.alu_op = decode_pkg::alu_add;
                    decode_pkg::fn_sub, decode_pkg::fn_subu: ctrl.alu_op = decode_pkg::alu_sub;
                    decode_pkg::fn_slt:  ctrl.alu_op = decode_pkg::alu_slt;
                    decode_pkg::fn_sltu: ctrl.alu_op = decode_pkg::alu_sltu;
                    decode_pkg::fn_and:  ctrl.alu_op = decode_pkg::alu_and;
                    decode_pkg::fn_or:   ctrl.alu_op = decode_pkg::alu_or;
                    decode_pkg::fn_xor:  ctrl.alu_op = decode_pkg::alu_xor;
                    decode_pkg::fn_nor:  ctrl.alu_op = decode_pkg::alu_nor;
                    decode_pkg::fn_sllv: ctrl.alu_op = decode_pkg::alu_sll;
                    decode_pkg::fn_srlv: ctrl.alu_op = decode_pkg::alu_srl;
                    decode_pkg::fn_srav: ctrl.alu_op = decode_pkg::alu_sra;
                    decode_pkg::fn_sll, decode_pkg::fn_srl, decode_pkg::fn_sra: begin
                        ctrl.src1_sel = decode_pkg::src1_sa; // shift amount from inst
                        ctrl.alu_op   = (funct == decode_pkg::fn_sll) ? decode_pkg::alu_sll :
                                        (funct == decode_pkg::fn_srl) ? decode_pkg::alu_srl :
                                                                        decode_pkg::alu_sra;
                    end
                    decode_pkg::fn_jr: begin
                        ctrl.src2_sel = decode_pkg::src2_none;
                        ctrl.rf_we    = 1'b0;
                        ctrl.rf_waddr = '0;
                        ctrl.br_kind  = decode_pkg::br_jr;
                    end
                    decode_pkg::fn_jalr: begin
                        ctrl.src1_sel = decode_pkg::src1_pc; // link value pc + 8
                        ctrl.src2_sel = decode_pkg::src2_eight;
                        ctrl.alu_op   = decode_pkg::alu_add;
                        ctrl.br_kind  = decode_pkg::br_jalr;
                    end
                    default: known = 1'b0;
                endcase
            end
            decode_pkg::op_addi, decode_pkg::op_addiu, decode_pkg::op_slti,
            decode_pkg::op_sltiu, decode_pkg::op_lw: begin
                ctrl.src1_sel = decode_pkg::src1_rs;
                ctrl.src2_sel = decode_pkg::src2_simm;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = ctrl.rt_addr;
                ctrl.alu_op   = (opcode == decode_pkg::op_slti)  ? decode_pkg::alu_slt  :
                                (opcode == decode_pkg::op_sltiu) ? decode_pkg::alu_sltu :
                                                                   decode_pkg::alu_add;
                ctrl.mem_en   = (opcode == decode_pkg::op_lw);
            end
            decode_pkg::op_andi, decode_pkg::op_ori, decode_pkg::op_xori: begin
                ctrl.src1_sel = decode_pkg::src1_rs;
                ctrl.src2_sel = decode_pkg::src2_zimm; // logical ops zero-extend
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = ctrl.rt_addr;
                ctrl.alu_op   = (opcode == decode_pkg::op_andi) ? decode_pkg::alu_and :
                                (opcode == decode_pkg::op_ori)  ? decode_pkg::alu_or  :
                                                                  decode_pkg::alu_xor;
            end
            decode_pkg::op_lui: begin
                ctrl.src2_sel = decode_pkg::src2_simm;
                ctrl.alu_op   = decode_pkg::alu_lui;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = ctrl.rt_addr;
            end
            decode_pkg::op_sw: begin
                ctrl.src1_sel = decode_pkg::src1_rs;
                ctrl.src2_sel = decode_pkg::src2_simm;
                ctrl.alu_op   = decode_pkg::alu_add; // address calc
                ctrl.mem_en   = 1'b1;
                ctrl.mem_we   = 1'b1;
            end
            decode_pkg::op_beq: ctrl.br_kind = decode_pkg::br_beq;
            decode_pkg::op_bne: ctrl.br_kind = decode_pkg::br_bne;
            decode_pkg::op_j:   ctrl.br_kind = decode_pkg::br_j;
            decode_pkg::op_jal: begin
                ctrl.src1_sel = decode_pkg::src1_pc;
                ctrl.src2_sel = decode_pkg::src2_eight;
                ctrl.alu_op   = decode_pkg::alu_add;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = decode_pkg::link_reg;
                ctrl.br_kind  = decode_pkg::br_jal;
            end
            default: known = 1'b0;
        endcase

        // bubble or unknown opcode must not write or branch
        if (!fetched.valid || !known) begin
            ctrl.alu_op  = decode_pkg::alu_none;
            ctrl.mem_en  = 1'b0;
            ctrl.mem_we  = 1'b0;
            ctrl.rf_we   = 1'b0;
            ctrl.br_kind = decode_pkg::br_none;
        end
    end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [decode_pkg::reg_addr_w-1:0]     raddr1,
    input  wire  [decode_pkg::reg_addr_w-1:0]     raddr2,
    output logic [decode_pkg::word_w-1:0]         rdata1,
    output logic [decode_pkg::word_w-1:0]         rdata2,
    input  wire  decode_pkg::rf_write_t           write
);

    logic [decode_pkg::word_w-1:0] regs [decode_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < decode_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write.we && write.addr != '0) begin
            regs[write.addr] <= write.data; // r0 never written
        end
    end

    // same-cycle write is not seen here, forwarding covers it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  wire  decode_pkg::ctrl_t           ctrl,
    input  wire  [decode_pkg::word_w-1:0]     rf_rs,
    input  wire  [decode_pkg::word_w-1:0]     rf_rt,
    input  wire  decode_pkg::rf_write_t       ex_fwd,
    input  wire  decode_pkg::rf_write_t       mem_fwd,
    input  wire  decode_pkg::rf_write_t       wb_fwd,
    input  wire                               ex_is_load,
    output logic [decode_pkg::word_w-1:0]     rs_value,
    output logic [decode_pkg::word_w-1:0]     rt_value,
    output logic                              stall_req
);

    // youngest producer first: ex, then mem, then wb
    function automatic logic [decode_pkg::word_w-1:0] pick(
        input logic [decode_pkg::reg_addr_w-1:0] idx,
        input logic [decode_pkg::word_w-1:0]     rf_val,
        input decode_pkg::rf_write_t             ex,
        input decode_pkg::rf_write_t             mem,
        input decode_pkg::rf_write_t             wb
    );
        logic [decode_pkg::word_w-1:0] value;
        value = rf_val;
        if (idx != '0) begin // r0 stays zero
            if (ex.we && ex.addr == idx) begin
                value = ex.data;
            end else if (mem.we && mem.addr == idx) begin
                value = mem.data;
            end else if (wb.we && wb.addr == idx) begin
                value = wb.data;
            end
        end
        return value;
    endfunction

    always_comb begin
        rs_value = pick(ctrl.rs_addr, rf_rs, ex_fwd, mem_fwd, wb_fwd);
        rt_value = pick(ctrl.rt_addr, rf_rt, ex_fwd, mem_fwd, wb_fwd);
    end

    // load data not ready until mem, so hold decode one cycle
    assign stall_req = ex_is_load &&
                       (ex_fwd.addr == ctrl.rs_addr || ex_fwd.addr == ctrl.rt_addr);

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire  decode_pkg::ctrl_t           ctrl,
    input  wire  [decode_pkg::word_w-1:0]     pc,
    input  wire  [decode_pkg::word_w-1:0]     inst,
    input  wire  [decode_pkg::word_w-1:0]     rs_value,
    input  wire  [decode_pkg::word_w-1:0]     rt_value,
    output decode_pkg::branch_t               branch
);

    logic [decode_pkg::word_w-1:0] pc_next;
    logic [decode_pkg::word_w-1:0] br_offset;
    logic [decode_pkg::word_w-1:0] jump_addr;
    logic                          equal;

    assign pc_next   = pc + decode_pkg::pc_step;
    assign br_offset = {{14{inst[15]}}, inst[15:0], 2'b00}; // word offset to bytes
    assign jump_addr = {pc_next[31:28], inst[25:0], 2'b00}; // same 256MB region
    assign equal     = (rs_value == rt_value);

    always_comb begin
        branch.taken  = 1'b0;
        branch.target = '0;
        case (ctrl.br_kind)
            decode_pkg::br_beq: begin
                branch.taken  = equal;
                branch.target = equal ? pc_next + br_offset : '0;
            end
            decode_pkg::br_bne: begin
                branch.taken  = !equal;
                branch.target = !equal ? pc_next + br_offset : '0;
            end
            decode_pkg::br_j, decode_pkg::br_jal: begin
                branch.taken  = 1'b1;
                branch.target = jump_addr;
            end
            decode_pkg::br_jr, decode_pkg::br_jalr: begin
                branch.taken  = 1'b1;
                branch.target = rs_value; // forwarded value
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                         clk,
    input  wire                         rst,
    input  wire  decode_pkg::stall_t    stall,
    input  wire  decode_pkg::fetch_t    fetch,
    input  wire  decode_pkg::rf_write_t wb_write,
    input  wire  decode_pkg::rf_write_t ex_fwd,
    input  wire  decode_pkg::rf_write_t mem_fwd,
    input  wire                         ex_is_load,
    output decode_pkg::id_to_ex_t       id_to_ex,
    output decode_pkg::branch_t         branch,
    output logic                        stall_req
);

    decode_pkg::fetch_t            fetch_r; // fetch-to-decode register
    decode_pkg::ctrl_t             ctrl;
    logic [decode_pkg::word_w-1:0] rf_rs;
    logic [decode_pkg::word_w-1:0] rf_rt;
    logic [decode_pkg::word_w-1:0] rs_value;
    logic [decode_pkg::word_w-1:0] rt_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_r <= '0;
        end else if (stall.id_stop && !stall.ex_stop) begin
            fetch_r <= '0; // bubble into ex
        end else if (!stall.id_stop) begin
            fetch_r <= fetch;
        end
        // both stops: hold
    end

    inst_decoder u_decoder (
        .fetched (fetch_r),
        .ctrl    (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (ctrl.rs_addr),
        .raddr2 (ctrl.rt_addr),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .write  (wb_write)
    );

    operand_forward u_forward (
        .ctrl       (ctrl),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_write), // wb is also the last forward source
        .ex_is_load (ex_is_load),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .stall_req  (stall_req)
    );

    branch_unit u_branch (
        .ctrl     (ctrl),
        .pc       (fetch_r.pc),
        .inst     (fetch_r.inst),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .branch   (branch)
    );

    always_comb begin
        id_to_ex.pc       = fetch_r.pc;
        id_to_ex.inst     = fetch_r.inst;
        id_to_ex.alu_op   = ctrl.alu_op;
        id_to_ex.src1_sel = ctrl.src1_sel;
        id_to_ex.src2_sel = ctrl.src2_sel;
        id_to_ex.mem_en   = ctrl.mem_en;
        id_to_ex.mem_we   = ctrl.mem_we;
        id_to_ex.rf_we    = ctrl.rf_we;
        id_to_ex.rf_waddr = ctrl.rf_waddr;
        id_to_ex.rs_value = rs_value;
        id_to_ex.rt_value = rt_value;
    end

endmodule

`default_nettype wire

// ==== testbench/decode_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva (
    input wire                        clk,
    input wire                        rst,
    input wire                        ex_is_load,
    input wire                        stall_req,
    input wire decode_pkg::rf_write_t ex_fwd,
    input wire decode_pkg::fetch_t    fetch_r,
    input wire decode_pkg::id_to_ex_t id_to_ex,
    input wire decode_pkg::branch_t   branch,
    input wire [31:0]                 rs_value
);

    // load-use stall only with a load in execute writing a source register
    a_stall_needs_load: assert property (@(posedge clk) disable iff (rst)
        stall_req |-> ex_is_load &&
            (ex_fwd.addr == fetch_r.inst[25:21] || ex_fwd.addr == fetch_r.inst[20:16]))
        else $error("stall request raised with no matching load in execute");

    a_bubble_quiet: assert property (@(posedge clk) disable iff (rst)
        !fetch_r.valid |-> !id_to_ex.rf_we && !id_to_ex.mem_en && !branch.taken)
        else $error("invalid decode register drives an enable");

    // register jumps go to the forwarded rs
    a_jr_target: assert property (@(posedge clk) disable iff (rst)
        fetch_r.valid && fetch_r.inst[31:26] == decode_pkg::op_special &&
        (fetch_r.inst[5:0] == decode_pkg::fn_jr || fetch_r.inst[5:0] == decode_pkg::fn_jalr)
        |-> branch.taken && branch.target == rs_value)
        else $error("register jump not taken to the rs value");

endmodule

bind decode_stage decode_stage_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .ex_is_load (ex_is_load),
    .stall_req  (stall_req),
    .ex_fwd     (ex_fwd),
    .fetch_r    (fetch_r),
    .id_to_ex   (id_to_ex),
    .branch     (branch),
    .rs_value   (rs_value)
);

`default_nettype wire

// ==== testbench/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    typedef struct packed {
        decode_pkg::stall_t    stall;
        logic [31:0]           inst;
        decode_pkg::rf_write_t ex_fwd;
        decode_pkg::rf_write_t mem_fwd;
        decode_pkg::rf_write_t wb_fwd;
        logic                  ex_is_load;
        logic [3:0]            flags; // rf_we, mem_en, mem_we, taken
        logic [4:0]            waddr;
        decode_pkg::alu_op_e   alu;
        decode_pkg::src1_sel_e src1;
        decode_pkg::src2_sel_e src2;
        logic [31:0]           target;
        logic                  stall_req;
        logic [1:0]            rs_src; // 0 model, 1 ex, 2 mem, 3 wb
        logic [1:0]            rt_src;
    } row_t;

    logic                  clk;
    logic                  rst;
    decode_pkg::stall_t    stall;
    decode_pkg::fetch_t    fetch;
    decode_pkg::rf_write_t wb_write;
    decode_pkg::rf_write_t ex_fwd;
    decode_pkg::rf_write_t mem_fwd;
    logic                  ex_is_load;
    decode_pkg::id_to_ex_t id_to_ex;
    decode_pkg::branch_t   branch;
    logic                  stall_req;

    logic [31:0] model [32]; // expected register contents
    row_t        rows [$];
    logic [31:0] row_pc = 32'h0040_1000;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          row_num = -1;

    decode_stage uut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .fetch      (fetch),
        .wb_write   (wb_write),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .ex_is_load (ex_is_load),
        .id_to_ex   (id_to_ex),
        .branch     (branch),
        .stall_req  (stall_req)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic decode_pkg::rf_write_t fwd(input logic [4:0] a, input logic [31:0] d);
        return {1'b1, a, d};
    endfunction

    function automatic logic [31:0] expect_operand(input logic [1:0] src,
                                                   input logic [4:0] idx, input row_t r);
        case (src)
            2'd1:    return r.ex_fwd.data;
            2'd2:    return r.mem_fwd.data;
            2'd3:    return r.wb_fwd.data;
            default: return model[idx];
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s (row %0d): got %h, expected %h", name, row_num, got, exp);
        end
    endtask

    task automatic add_row(
        input logic [1:0] stl, input logic [31:0] inst,
        input decode_pkg::rf_write_t exf, input decode_pkg::rf_write_t mmf,
        input decode_pkg::rf_write_t wbf, input logic ld,
        input logic [3:0] flags, input logic [4:0] waddr, input decode_pkg::alu_op_e alu,
        input decode_pkg::src1_sel_e s1, input decode_pkg::src2_sel_e s2,
        input logic [31:0] target, input logic stl_req,
        input logic [1:0] rs_src, input logic [1:0] rt_src);
        row_t r;
        r.stall      = stl;
        r.inst       = inst;
        r.ex_fwd     = exf;
        r.mem_fwd    = mmf;
        r.wb_fwd     = wbf;
        r.ex_is_load = ld;
        r.flags      = flags;
        r.waddr      = waddr;
        r.alu        = alu;
        r.src1       = s1;
        r.src2       = s2;
        r.target     = target;
        r.stall_req  = stl_req;
        r.rs_src     = rs_src;
        r.rt_src     = rt_src;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // plain decode, operands from the register file
        add_row(2'b00, rtype(1, 2, 3, 0, decode_pkg::fn_addu), '0, '0, '0, 1'b0,
                4'b1000, 5'd3, decode_pkg::alu_add, decode_pkg::src1_rs, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, rtype(5, 6, 4, 0, decode_pkg::fn_slt), '0, '0, '0, 1'b0,
                4'b1000, 5'd4, decode_pkg::alu_slt, decode_pkg::src1_rs, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, itype(decode_pkg::op_addiu, 1, 7, 16'h1234), '0, '0, '0, 1'b0,
                4'b1000, 5'd7, decode_pkg::alu_add, decode_pkg::src1_rs,
                decode_pkg::src2_simm, 32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, itype(decode_pkg::op_ori, 2, 8, 16'hff00), '0, '0, '0, 1'b0,
                4'b1000, 5'd8, decode_pkg::alu_or, decode_pkg::src1_rs,
                decode_pkg::src2_zimm, 32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, itype(decode_pkg::op_lui, 0, 9, 16'habcd), '0, '0, '0, 1'b0,
                4'b1000, 5'd9, decode_pkg::alu_lui, decode_pkg::src1_none,
                decode_pkg::src2_simm, 32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, rtype(0, 11, 10, 5, decode_pkg::fn_sra), '0, '0, '0, 1'b0,
                4'b1000, 5'd10, decode_pkg::alu_sra, decode_pkg::src1_sa, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, itype(decode_pkg::op_lw, 13, 12, 16'h0008), '0, '0, '0, 1'b0,
                4'b1100, 5'd12, decode_pkg::alu_add, decode_pkg::src1_rs,
                decode_pkg::src2_simm, 32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, itype(decode_pkg::op_sw, 15, 14, 16'h0004), '0, '0, '0, 1'b0,
                4'b0110, 5'd0, decode_pkg::alu_add, decode_pkg::src1_rs,
                decode_pkg::src2_simm, 32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, jtype(decode_pkg::op_jal, 26'h0100040), '0, '0, '0, 1'b0,
                4'b1001, 5'd31, decode_pkg::alu_add, decode_pkg::src1_pc,
                decode_pkg::src2_eight, 32'h0040_0100, 1'b0, 2'd0, 2'd0);
        // forward priority ex > mem > wb, r0 never forwarded
        add_row(2'b00, rtype(10, 0, 1, 0, decode_pkg::fn_add), fwd(10, 32'h1111_0001),
                fwd(10, 32'h2222_0002), fwd(10, 32'h3333_0003), 1'b0,
                4'b1000, 5'd1, decode_pkg::alu_add, decode_pkg::src1_rs, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd1, 2'd0);
        add_row(2'b00, rtype(0, 10, 2, 0, decode_pkg::fn_or), fwd(0, 32'hdead_0000),
                fwd(10, 32'h2222_0012), fwd(10, 32'h3333_0013), 1'b0,
                4'b1000, 5'd2, decode_pkg::alu_or, decode_pkg::src1_rs, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd0, 2'd2);
        add_row(2'b00, rtype(11, 12, 3, 0, decode_pkg::fn_xor), '0, '0,
                fwd(11, 32'h4444_0004), 1'b0,
                4'b1000, 5'd3, decode_pkg::alu_xor, decode_pkg::src1_rs, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd3, 2'd0);
        // branches and jumps
        add_row(2'b00, itype(decode_pkg::op_beq, 5, 6, 16'h0010), fwd(5, 32'h5a5a),
                fwd(6, 32'h5a5a), '0, 1'b0,
                4'b0001, 5'd0, decode_pkg::alu_none, decode_pkg::src1_none,
                decode_pkg::src2_none, 32'h0040_1044, 1'b0, 2'd1, 2'd2);
        add_row(2'b00, itype(decode_pkg::op_bne, 5, 6, 16'hfffe), fwd(5, 32'h5a5a),
                fwd(6, 32'h5a5a), '0, 1'b0,
                4'b0000, 5'd0, decode_pkg::alu_none, decode_pkg::src1_none,
                decode_pkg::src2_none, 32'h0, 1'b0, 2'd1, 2'd2);
        add_row(2'b00, itype(decode_pkg::op_bne, 5, 6, 16'hfffe), fwd(5, 32'h1),
                fwd(6, 32'h2), '0, 1'b0,
                4'b0001, 5'd0, decode_pkg::alu_none, decode_pkg::src1_none,
                decode_pkg::src2_none, 32'h0040_0ffc, 1'b0, 2'd1, 2'd2);
        add_row(2'b00, jtype(decode_pkg::op_j, 26'h0100040), '0, '0, '0, 1'b0,
                4'b0001, 5'd0, decode_pkg::alu_none, decode_pkg::src1_none,
                decode_pkg::src2_none, 32'h0040_0100, 1'b0, 2'd0, 2'd0);
        add_row(2'b00, rtype(8, 0, 0, 0, decode_pkg::fn_jr), fwd(8, 32'h0040_2000), '0, '0,
                1'b0, 4'b0001, 5'd0, decode_pkg::alu_none, decode_pkg::src1_rs,
                decode_pkg::src2_none, 32'h0040_2000, 1'b0, 2'd1, 2'd0);
        add_row(2'b00, rtype(9, 0, 31, 0, decode_pkg::fn_jalr), '0, fwd(9, 32'h0040_3000),
                '0, 1'b0, 4'b1001, 5'd31, decode_pkg::alu_add, decode_pkg::src1_pc,
                decode_pkg::src2_eight, 32'h0040_3000, 1'b0, 2'd2, 2'd0);
        // load-use, then hold and bubble
        add_row(2'b00, rtype(8, 9, 3, 0, decode_pkg::fn_addu), fwd(9, 32'h5555_0009), '0,
                '0, 1'b1, 4'b1000, 5'd3, decode_pkg::alu_add, decode_pkg::src1_rs,
                decode_pkg::src2_rt, 32'h0, 1'b1, 2'd0, 2'd1);
        add_row(2'b00, rtype(8, 9, 3, 0, decode_pkg::fn_addu), fwd(8, 32'h7777_0008), '0,
                '0, 1'b1, 4'b1000, 5'd3, decode_pkg::alu_add, decode_pkg::src1_rs,
                decode_pkg::src2_rt, 32'h0, 1'b1, 2'd1, 2'd0);
        add_row(2'b00, rtype(8, 9, 3, 0, decode_pkg::fn_addu), fwd(12, 32'h6666_000c), '0,
                '0, 1'b1, 4'b1000, 5'd3, decode_pkg::alu_add, decode_pkg::src1_rs,
                decode_pkg::src2_rt, 32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b11, rtype(5, 6, 4, 0, decode_pkg::fn_sub), '0, '0, '0, 1'b0,
                4'b1000, 5'd3, decode_pkg::alu_add, decode_pkg::src1_rs, decode_pkg::src2_rt,
                32'h0, 1'b0, 2'd0, 2'd0);
        add_row(2'b10, rtype(5, 6, 4, 0, decode_pkg::fn_sub), '0, '0, '0, 1'b0,
                4'b0000, 5'd0, decode_pkg::alu_none, decode_pkg::src1_none,
                decode_pkg::src2_none, 32'h0, 1'b0, 2'd0, 2'd0);
    endtask

    task automatic fill_regs();
        logic [31:0] seed;
        seed = 32'hfa244ae2;
        for (int i = 1; i < 32; i++) begin
            seed = lcg_next(seed);
            @(posedge clk);
            wb_write <= {1'b1, 5'(i), seed};
            model[i] = seed;
        end
        @(posedge clk);
        wb_write <= '0;
    endtask

    // outputs must settle inactive soon after reset
    task automatic wait_idle();
        int n;
        n = 0;
        while ((id_to_ex.rf_we || id_to_ex.mem_en || id_to_ex.mem_we || branch.taken)
               && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (n >= 50) begin
            timeouts++;
            $display("Timeout: decode stage outputs did not go idle after reset");
        end
    endtask

    initial begin
        row_t        r;
        logic [31:0] cur_inst;
        logic        cur_valid;
        rst        = 1'b1;
        stall      = '0;
        // a valid jal waits at the input, only rst keeps decode idle
        fetch      = {1'b1, row_pc, jtype(decode_pkg::op_jal, 26'h0100040)};
        wb_write   = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        ex_is_load = 1'b0;
        cur_inst   = '0;
        cur_valid  = 1'b0;
        model[0]   = '0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        wait_idle();
        check_val("rf_we", id_to_ex.rf_we, 0);
        check_val("mem_en", id_to_ex.mem_en, 0);
        check_val("mem_we", id_to_ex.mem_we, 0);
        check_val("taken", branch.taken, 0);
        fill_regs();

        foreach (rows[i]) begin
            r       = rows[i];
            row_num = i;
            @(posedge clk);
            stall      <= r.stall;
            fetch      <= {1'b1, row_pc, r.inst};
            ex_fwd     <= r.ex_fwd;
            mem_fwd    <= r.mem_fwd;
            wb_write   <= r.wb_fwd;
            ex_is_load <= r.ex_is_load;
            // expected decode register after the capture edge
            if (!r.stall.id_stop) begin
                cur_inst  = r.inst;
                cur_valid = 1'b1;
            end else if (!r.stall.ex_stop) begin
                cur_inst  = '0;
                cur_valid = 1'b0;
            end
            @(posedge clk);
            @(negedge clk);
            check_val("inst", id_to_ex.inst, cur_inst);
            check_val("rf_we", id_to_ex.rf_we, r.flags[3]);
            check_val("mem_en", id_to_ex.mem_en, r.flags[2]);
            check_val("mem_we", id_to_ex.mem_we, r.flags[1]);
            check_val("taken", branch.taken, r.flags[0]);
            check_val("target", branch.target, r.target);
            check_val("stall_req", stall_req, r.stall_req);
            check_val("rs_value", id_to_ex.rs_value,
                      expect_operand(r.rs_src, cur_inst[25:21], r));
            check_val("rt_value", id_to_ex.rt_value,
                      expect_operand(r.rt_src, cur_inst[20:16], r));
            if (cur_valid) begin
                check_val("pc", id_to_ex.pc, row_pc);
                check_val("rf_waddr", id_to_ex.rf_waddr, r.waddr);
                check_val("alu_op", id_to_ex.alu_op, r.alu);
                check_val("src1_sel", id_to_ex.src1_sel, r.src1);
                check_val("src2_sel", id_to_ex.src2_sel, r.src2);
            end
            if (r.wb_fwd.we && r.wb_fwd.addr != 0) begin
                model[r.wb_fwd.addr] = r.wb_fwd.data;
            end
        end

        $display("decode_stage_tb: %0d checks, %0d mismatches, %0d timeouts",
                 checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/decode_pkg.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_forward.sv
source/branch_unit.sv
source/decode_stage.sv
testbench/decode_stage_sva.sv
testbench/decode_stage_tb.sv
